//--- ahb_pkg.sv
// AHB-Lite shared types and memory map; word transfers only, single master, no HPROT or HSIZE
package ahb_pkg;

  // --------------------
  // Transfer and response codes
  // --------------------
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic RESP_OKAY  = 1'b0;
  localparam logic RESP_ERROR = 1'b1;

  // --------------------
  // Memory map
  // --------------------
  // SRAM window, 256 words from address zero
  localparam logic [31:0] SRAM_BASE  = 32'h0000_0000;
  localparam int          SRAM_WORDS = 256;

  // GPIO window, 16 bytes
  localparam logic [31:0] GPIO_BASE  = 32'h4000_0000;
  localparam int          GPIO_WIDTH = 8;

  // Register offsets inside the GPIO window
  localparam logic [3:0] GPIO_OUT_OFS = 4'h0;
  localparam logic [3:0] GPIO_DIR_OFS = 4'h4;
  localparam logic [3:0] GPIO_IN_OFS  = 4'h8;

  // Slave indices into select vector and response array
  localparam int NUM_SLAVES  = 3;
  localparam int SLV_SRAM    = 0;
  localparam int SLV_GPIO    = 1;
  localparam int SLV_DEFAULT = 2;

  // --------------------
  // Bus structs
  // --------------------
  // Request shared by decoder and all slaves
  typedef struct packed {
    logic [31:0] haddr;
    logic [1:0]  htrans;
    logic        hwrite;
    logic [31:0] hwdata;
    logic        hready;   // bus-wide ready, fed back from the mux
  } ahb_req_t;

  // One slave's answer
  typedef struct packed {
    logic [31:0] hrdata;
    logic        hresp;
    logic        hreadyout;
  } ahb_rsp_t;

endpackage

//--- ahb_addr_decoder.sv
// Combinational AHB decoder; exactly one select is set, unmapped space goes to the default slave
`timescale 1ns/1ps

module ahb_addr_decoder
(
  input  ahb_pkg::ahb_req_t                req,
  output logic [ahb_pkg::NUM_SLAVES-1:0]   sel
);

  import ahb_pkg::*;

  // Offset of the address into the SRAM window
  logic [31:0] sram_ofs;
  logic        sram_hit;
  logic        gpio_hit;

  // --------------------
  // Window compares
  // --------------------
  assign sram_ofs = req.haddr - SRAM_BASE;

  // Out-of-window offsets wrap high, so one compare covers both sides
  assign sram_hit = (sram_ofs < SRAM_WORDS * 4);

  // GPIO window is 16 bytes, aligned
  assign gpio_hit = (req.haddr[31:4] == GPIO_BASE[31:4]);

  // --------------------
  // One-hot select
  // --------------------
  always_comb
  begin
    sel = '0;
    if (sram_hit)
    begin
      sel[SLV_SRAM] = 1'b1;
    end
    else if (gpio_hit)
    begin
      sel[SLV_GPIO] = 1'b1;
    end
    else
    begin
      // Anything else answers with ERROR
      sel[SLV_DEFAULT] = 1'b1;
    end
  end

endmodule

//--- ahb_default_slave.sv
// AHB default slave; every accepted transfer gets a two-cycle ERROR with zero read data
`timescale 1ns/1ps

module ahb_default_slave
(
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic              ahb_sel,
  input  ahb_pkg::ahb_req_t req,
  output ahb_pkg::ahb_rsp_t rsp
);

  import ahb_pkg::*;

  logic accept;
  logic hready_q;
  logic hresp_q;

  // Valid transfer in the address phase
  assign accept = ahb_sel & req.htrans[1] & req.hready;

  // Ready drops for one cycle after an accepted transfer
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      hready_q <= 1'b1;
    end
    else
    begin
      hready_q <= ~accept | ~hready_q;
    end
  end

  // Response held through the wait cycle
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      hresp_q <= RESP_OKAY;
    end
    else if (hready_q)
    begin
      hresp_q <= accept ? RESP_ERROR : RESP_OKAY;
    end
  end

  // No data ever comes back from unmapped space
  assign rsp.hrdata    = '0;
  assign rsp.hresp     = hresp_q;
  assign rsp.hreadyout = hready_q;

endmodule

//--- ahb_sram_slave.sv
// Zero-wait word SRAM on AHB; 32-bit accesses only, contents undefined after reset
`timescale 1ns/1ps

module ahb_sram_slave
(
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic              ahb_sel,
  input  ahb_pkg::ahb_req_t req,
  output ahb_pkg::ahb_rsp_t rsp
);

  import ahb_pkg::*;

  // --------------------
  // Storage and pipeline
  // --------------------
  logic [31:0]                   mem [SRAM_WORDS];
  logic [$clog2(SRAM_WORDS)-1:0] word_idx;
  logic [$clog2(SRAM_WORDS)-1:0] addr_q;
  logic [31:0]                   rdata_q;
  logic                          accept;
  logic                          wr_q;
  logic                          fwd_hit;

  // Byte address to word index
  assign word_idx = req.haddr[$clog2(SRAM_WORDS)+1:2];

  // Address phase taken
  assign accept = ahb_sel & req.htrans[1] & req.hready;

  // Pending write to the word now being read
  assign fwd_hit = wr_q & (addr_q == word_idx);

  // Write flag for the data phase
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      wr_q <= 1'b0;
    end
    else if (req.hready)
    begin
      wr_q <= accept & req.hwrite;
    end
  end

  // Array write, address capture and read
  always_ff @(posedge HCLK)
  begin
    // Commit write at end of its data phase
    if (wr_q && req.hready)
    begin
      mem[addr_q] <= req.hwdata;
    end

    if (accept)
    begin
      addr_q <= word_idx;
    end

    // Read lands in the data phase; bypass the write finishing at this same edge
    if (accept && !req.hwrite)
    begin
      if (fwd_hit)
      begin
        rdata_q <= req.hwdata;
      end
      else
      begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  // --------------------
  // Response
  // --------------------
  // Never stalls, never errors
  assign rsp.hrdata    = rdata_q;
  assign rsp.hresp     = RESP_OKAY;
  assign rsp.hreadyout = 1'b1;

endmodule

//--- ahb_gpio_regs.sv
// GPIO register slave; word accesses, input offset is read-only, other offsets read as zero
`timescale 1ns/1ps

module ahb_gpio_regs
(
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic                             ahb_sel,
  input  ahb_pkg::ahb_req_t                req,
  input  logic [ahb_pkg::GPIO_WIDTH-1:0]   gpio_in,
  output ahb_pkg::ahb_rsp_t                rsp,
  output logic [ahb_pkg::GPIO_WIDTH-1:0]   gpio_out,
  output logic [ahb_pkg::GPIO_WIDTH-1:0]   gpio_oe
);

  import ahb_pkg::*;

  logic                  accept;
  logic                  wr_q;
  logic [1:0]            ofs_q;
  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] dir_q;
  logic [GPIO_WIDTH-1:0] in_meta;
  logic [GPIO_WIDTH-1:0] in_sync;
  logic [31:0]           rdata;

  assign accept = ahb_sel & req.htrans[1] & req.hready;

  // --------------------
  // Address phase
  // --------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      wr_q <= 1'b0;
    end
    else if (req.hready)
    begin
      wr_q <= accept & req.hwrite;
    end
  end

  // Word offset within the window
  always_ff @(posedge HCLK)
  begin
    if (accept)
    begin
      ofs_q <= req.haddr[3:2];
    end
  end

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      out_q   <= '0;
      dir_q   <= '0;
      in_meta <= '0;
      in_sync <= '0;
    end
    else
    begin
      // Two-flop synchronizer on the pins
      in_meta <= gpio_in;
      in_sync <= in_meta;
      // Data-phase write; input offset ignored
      if (wr_q && req.hready)
      begin
        if (ofs_q == GPIO_OUT_OFS[3:2])
        begin
          out_q <= req.hwdata[GPIO_WIDTH-1:0];
        end
        else if (ofs_q == GPIO_DIR_OFS[3:2])
        begin
          dir_q <= req.hwdata[GPIO_WIDTH-1:0];
        end
      end
    end
  end

  // Read mux, zero-extended
  always_comb
  begin
    rdata = '0;
    case (ofs_q)
      GPIO_OUT_OFS[3:2]: rdata[GPIO_WIDTH-1:0] = out_q;
      GPIO_DIR_OFS[3:2]: rdata[GPIO_WIDTH-1:0] = dir_q;
      GPIO_IN_OFS[3:2]:  rdata[GPIO_WIDTH-1:0] = in_sync;
      default:           rdata = '0;
    endcase
  end

  assign gpio_out      = out_q;
  assign gpio_oe       = dir_q;
  assign rsp.hrdata    = rdata;
  assign rsp.hresp     = RESP_OKAY;
  assign rsp.hreadyout = 1'b1;

endmodule

//--- ahb_slave_mux.sv
// AHB response mux; data-phase select follows HREADY, idle data phases answer OKAY and ready
`timescale 1ns/1ps

module ahb_slave_mux
(
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic [ahb_pkg::NUM_SLAVES-1:0]   sel,
  input  logic [1:0]                       htrans,
  input  ahb_pkg::ahb_rsp_t                slv_rsp [ahb_pkg::NUM_SLAVES],
  output logic [31:0]                      HRDATA,
  output logic                             HRESP,
  output logic                             HREADY
);

  import ahb_pkg::*;

  // Slave owning the current data phase
  logic [NUM_SLAVES-1:0] sel_q;

  // --------------------
  // Data-phase select
  // --------------------
  // Idle or busy address phases leave nothing selected
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      sel_q <= '0;
    end
    else if (HREADY)
    begin
      sel_q <= htrans[1] ? sel : '0;
    end
  end

  // --------------------
  // Response routing
  // --------------------
  always_comb
  begin
    // Idle answer
    HRDATA = '0;
    HRESP  = RESP_OKAY;
    HREADY = 1'b1;
    // Select is one-hot, so at most one match
    for (int i = 0; i < NUM_SLAVES; i++)
    begin
      if (sel_q[i])
      begin
        HRDATA = slv_rsp[i].hrdata;
        HRESP  = slv_rsp[i].hresp;
        HREADY = slv_rsp[i].hreadyout;
      end
    end
  end

endmodule

//--- ahb_subsystem.sv
// AHB-Lite slave subsystem top; one master, SRAM at 0x0, GPIO at 0x4000_0000, rest errors
`timescale 1ns/1ps

module ahb_subsystem
(
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic [31:0]                      HADDR,
  input  logic [1:0]                       HTRANS,
  input  logic                             HWRITE,
  input  logic [31:0]                      HWDATA,
  input  logic [ahb_pkg::GPIO_WIDTH-1:0]   gpio_in,
  output logic [31:0]                      HRDATA,
  output logic                             HRESP,
  output logic                             HREADY,
  output logic [ahb_pkg::GPIO_WIDTH-1:0]   gpio_out,
  output logic [ahb_pkg::GPIO_WIDTH-1:0]   gpio_oe
);

  import ahb_pkg::*;

  ahb_req_t              req;
  ahb_rsp_t              slv_rsp [NUM_SLAVES];
  logic [NUM_SLAVES-1:0] sel;

  // Master signals plus fed-back ready
  assign req = '{haddr: HADDR, htrans: HTRANS, hwrite: HWRITE,
                 hwdata: HWDATA, hready: HREADY};

  // --------------------
  // Decode and slaves
  // --------------------
  ahb_addr_decoder u_decoder (.req(req), .sel(sel));

  ahb_sram_slave u_sram (
    .HCLK(HCLK), .HRESETn(HRESETn), .ahb_sel(sel[SLV_SRAM]),
    .req(req), .rsp(slv_rsp[SLV_SRAM])
  );

  ahb_gpio_regs u_gpio (
    .HCLK(HCLK), .HRESETn(HRESETn), .ahb_sel(sel[SLV_GPIO]),
    .req(req), .gpio_in(gpio_in), .rsp(slv_rsp[SLV_GPIO]),
    .gpio_out(gpio_out), .gpio_oe(gpio_oe)
  );

  ahb_default_slave u_default (
    .HCLK(HCLK), .HRESETn(HRESETn), .ahb_sel(sel[SLV_DEFAULT]),
    .req(req), .rsp(slv_rsp[SLV_DEFAULT])
  );

  // Response back to the master
  ahb_slave_mux u_mux (
    .HCLK(HCLK), .HRESETn(HRESETn), .sel(sel), .htrans(HTRANS),
    .slv_rsp(slv_rsp), .HRDATA(HRDATA), .HRESP(HRESP), .HREADY(HREADY)
  );

endmodule

//--- tb_clock_gen.sv
// Testbench clock and reset; 4 ns HCLK, HRESETn held low for the first two cycles
`timescale 1ns/1ps

module tb_clock_gen
(
  output logic HCLK,
  output logic HRESETn
);

  // Free-running clock, 2 ns per half period
  initial
  begin
    HCLK = 1'b0;
    forever
    begin
      #2 HCLK = ~HCLK;
    end
  end

  // Release on a falling edge, away from the active edge
  initial
  begin
    HRESETn = 1'b0;
    repeat (2) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
  end

endmodule

//--- tb_ahb_subsystem.sv
// Self-checking testbench; transfers from ahb_stimulus.txt, word accesses, one master only
`timescale 1ns/1ps

module tb_ahb_subsystem;

  import ahb_pkg::*;

  // Longest wait on HREADY or reset, in cycles
  localparam int TIMEOUT_CYCLES = 16;

  // One line of the stimulus file
  typedef struct packed {
    logic        valid;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic        resp;
  } xfer_t;

  logic                  HCLK;
  logic                  HRESETn;
  logic [31:0]           HADDR;
  logic [1:0]            HTRANS;
  logic                  HWRITE;
  logic [31:0]           HWDATA;
  logic [GPIO_WIDTH-1:0] gpio_in;
  logic [31:0]           HRDATA;
  logic                  HRESP;
  logic                  HREADY;
  logic [GPIO_WIDTH-1:0] gpio_out;
  logic [GPIO_WIDTH-1:0] gpio_oe;

  // Transfer now in its data phase, and the one after it
  xfer_t                 pend;
  xfer_t                 nxt;
  logic [GPIO_WIDTH-1:0] exp_out;
  logic [GPIO_WIDTH-1:0] exp_oe;
  integer                seed;
  int                    n_tests;
  int                    n_bad;
  int                    n_errors;
  bit                    timed_out;

  // --------------------
  // Clock, reset, DUT
  // --------------------
  tb_clock_gen u_clk_gen (.HCLK(HCLK), .HRESETn(HRESETn));

  ahb_subsystem dut_i (
    .HCLK(HCLK), .HRESETn(HRESETn), .HADDR(HADDR), .HTRANS(HTRANS),
    .HWRITE(HWRITE), .HWDATA(HWDATA), .gpio_in(gpio_in), .HRDATA(HRDATA),
    .HRESP(HRESP), .HREADY(HREADY), .gpio_out(gpio_out), .gpio_oe(gpio_oe)
  );

  // --------------------
  // Helpers
  // --------------------
  task automatic note_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    n_errors++;
  endtask

  // Pins follow the last completed register write
  task automatic check_pins();
    assert (gpio_out === exp_out)
    else note_mismatch($sformatf("gpio_out %h, expected %h", gpio_out, exp_out));
    assert (gpio_oe === exp_oe)
    else note_mismatch($sformatf("gpio_oe %h, expected %h", gpio_oe, exp_oe));
  endtask

  // Address phase of x, write data of the pending transfer
  task automatic drive_cycle(input xfer_t x);
    HADDR  = x.addr;
    HWRITE = x.valid && (x.op == "W");
    if (!x.valid || x.op == "I")
    begin
      HTRANS = HTRANS_IDLE;
    end
    else if (pend.valid && pend.resp == RESP_OKAY && pend.op == x.op &&
             x.addr == pend.addr + 32'd4)
    begin
      // Next word of a run
      HTRANS = HTRANS_SEQ;
    end
    else
    begin
      HTRANS = HTRANS_NONSEQ;
    end
    HWDATA = (pend.valid && pend.op == "W") ? pend.data : 32'h0;
  endtask

  // Data phase of pend; ERROR costs one wait cycle, OKAY none
  task automatic finish_transfer();
    int          waits;
    int          errs_before;
    logic [31:0] exp_data;
    string       verdict;
    waits       = 0;
    errs_before = n_errors;
    exp_data    = (pend.op == "R" && pend.resp == RESP_OKAY) ? pend.data : 32'h0;
    // Input register returns the driven pins
    if (pend.op == "R" && pend.addr == GPIO_BASE + 32'(GPIO_IN_OFS))
    begin
      exp_data = {{(32-GPIO_WIDTH){1'b0}}, gpio_in};
    end
    // Wait cycles show ERROR with zero data
    while (HREADY !== 1'b1 && waits < TIMEOUT_CYCLES)
    begin
      assert (HRESP === RESP_ERROR && HRDATA === 32'h0)
      else note_mismatch($sformatf("%h wait cycle HRESP %b HRDATA %h",
                                   pend.addr, HRESP, HRDATA));
      waits++;
      @(negedge HCLK);
    end
    if (HREADY !== 1'b1)
    begin
      $display("Timeout: HREADY stayed low for %0d cycles on the transfer to %h",
               waits, pend.addr);
      timed_out = 1'b1;
    end
    else
    begin
      assert (waits == ((pend.resp == RESP_ERROR) ? 1 : 0))
      else note_mismatch($sformatf("%h took %0d wait cycles", pend.addr, waits));
      assert (HRESP === pend.resp)
      else note_mismatch($sformatf("%h HRESP %b, expected %b", pend.addr, HRESP, pend.resp));
      // Write data phases carry no read data unless errored
      if (pend.op != "W" || pend.resp == RESP_ERROR)
      begin
        assert (HRDATA === exp_data)
        else note_mismatch($sformatf("%h HRDATA %h, expected %h", pend.addr, HRDATA, exp_data));
      end
      // GPIO registers take the write at the end of this phase
      if (pend.op == "W" && pend.resp == RESP_OKAY)
      begin
        if (pend.addr == GPIO_BASE + 32'(GPIO_OUT_OFS))
        begin
          exp_out = pend.data[GPIO_WIDTH-1:0];
        end
        else if (pend.addr == GPIO_BASE + 32'(GPIO_DIR_OFS))
        begin
          exp_oe = pend.data[GPIO_WIDTH-1:0];
        end
      end
    end
    n_tests++;
    if (n_errors != errs_before || timed_out)
    begin
      n_bad++;
      verdict = "fail";
    end
    else
    begin
      verdict = "ok";
    end
    $display("test %0d: %c %h %s", n_tests, pend.op, pend.addr, verdict);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial
  begin
    int          fd;
    int          rc;
    int          cycles;
    string       line;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] resp;
    logic [31:0] rnd;

    seed      = 32'h7f3e;
    rnd       = $random(seed);
    gpio_in   = rnd[GPIO_WIDTH-1:0];
    HADDR     = 32'h0;
    HTRANS    = HTRANS_IDLE;
    HWRITE    = 1'b0;
    HWDATA    = 32'h0;
    pend      = '0;
    nxt       = '0;
    exp_out   = '0;
    exp_oe    = '0;
    n_tests   = 0;
    n_bad     = 0;
    n_errors  = 0;
    timed_out = 1'b0;

    cycles = 0;
    while (HRESETn !== 1'b1 && cycles < TIMEOUT_CYCLES)
    begin
      @(negedge HCLK);
      cycles++;
    end
    if (HRESETn !== 1'b1)
    begin
      $display("Timeout: HRESETn never went high");
      timed_out = 1'b1;
    end
    else
    begin
      // Idle bus straight after reset
      @(negedge HCLK);
      assert (HREADY === 1'b1 && HRESP === RESP_OKAY)
      else note_mismatch($sformatf("after reset HREADY %b HRESP %b", HREADY, HRESP));
      check_pins();
      fd = $fopen("ahb_stimulus.txt", "r");
      if (fd == 0)
      begin
        $display("Error: cannot open ahb_stimulus.txt");
        n_errors++;
      end
      else
      begin
        while (!timed_out && !$feof(fd))
        begin
          line = "";
          rc   = $fgets(line, fd);
          // Blank and comment lines
          if (rc == 0 || line.len() < 2 || line.getc(0) == "#")
          begin
            continue;
          end
          if ($sscanf(line, "%c %h %h %h", op, addr, data, resp) != 4)
          begin
            $display("Error: cannot read stimulus line %s", line);
            n_errors++;
            continue;
          end
          nxt = '{valid: 1'b1, op: op, addr: addr, data: data, resp: resp[0]};
          @(negedge HCLK);
          check_pins();
          drive_cycle(nxt);
          if (pend.valid)
          begin
            finish_transfer();
          end
          pend = nxt;
        end
        $fclose(fd);
        // Drain the last data phase, then let the pins settle
        if (!timed_out)
        begin
          nxt = '0;
          @(negedge HCLK);
          check_pins();
          drive_cycle(nxt);
          if (pend.valid)
          begin
            finish_transfer();
          end
          @(negedge HCLK);
          check_pins();
        end
      end
    end

    $display("tests %0d, failed tests %0d, check errors %0d", n_tests, n_bad, n_errors);
    if (timed_out || n_errors != 0)
    begin
      $display("TESTBENCH FAILED");
    end
    else
    begin
      $display("TESTBENCH PASSED");
    end
    $finish;
  end

endmodule

//--- ahb_stimulus.txt
# Columns: op (W write, R read, I idle), address, data (write or expected read), resp (0 OKAY, 1 ERROR)
# Reads of 40000008 expect the driven gpio_in, so their data column is ignored
# SRAM writes back to back, then read back
I 00000000 00000000 0
W 00000000 a5a5a5a5 0
W 00000004 5a5a5a5a 0
W 000003fc deadbeef 0
R 00000000 a5a5a5a5 0
R 00000004 5a5a5a5a 0
R 000003fc deadbeef 0
# Read straight after a write to the same word
W 00000010 11223344 0
R 00000010 11223344 0
I 00000000 00000000 0
# GPIO output and direction registers
W 40000000 000000c3 0
W 40000004 0000000f 0
R 40000000 000000c3 0
R 40000004 0000000f 0
# GPIO input register and an undefined offset
R 40000008 00000000 0
R 4000000c 00000000 0
# Unmapped space, back to back, then recovery
R 80000000 00000000 1
W 00000400 12345678 1
R 00000004 5a5a5a5a 0
W 40000010 0000ffff 1
W 40000000 0000003c 0
R 40000000 0000003c 0
I 00000000 00000000 0
I 00000000 00000000 0

//--- compile.f
ahb_pkg.sv
ahb_addr_decoder.sv
ahb_default_slave.sv
ahb_sram_slave.sv
ahb_gpio_regs.sv
ahb_slave_mux.sv
ahb_subsystem.sv
tb_clock_gen.sv
tb_ahb_subsystem.sv

//--- Makefile
TOP = tb_ahb_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f compile.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
